// File: hw/pipe_params.svh
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// Datapath and register file
`define PIPE_DATA_W  32
`define PIPE_REG_AW  5
`define PIPE_REG_NUM 32
`define PIPE_SHAMT_W 5

// Data memory, word addressed
`define PIPE_DMEM_AW 8

`endif

// File: hw/pipe_pkg.sv
`default_nettype none

`include "pipe_params.svh"

package pipe_pkg;

   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_AND    = 4'd2,
      ALU_OR     = 4'd3,
      ALU_XOR    = 4'd4,
      ALU_SLT    = 4'd5, // Signed compare
      ALU_SLL    = 4'd6,
      ALU_SRL    = 4'd7,
      ALU_PASS_B = 4'd8
   } alu_op_t;

   typedef enum logic [1:0] {
      WB_ALU = 2'd0,
      WB_MEM = 2'd1,
      WB_PC4 = 2'd2
   } wb_sel_t;

   typedef struct packed {
      logic                    valid;
      alu_op_t                 op;
      logic [`PIPE_DATA_W-1:0] a;
      logic [`PIPE_DATA_W-1:0] b;
      logic [`PIPE_DATA_W-1:0] store_data;
      logic [`PIPE_REG_AW-1:0] rd;
      logic                    reg_write;
      logic                    mem_read;
      logic                    mem_write;
      wb_sel_t                 wb_sel;
      logic                    halt;
      logic [`PIPE_DATA_W-1:0] pc4;
   } id_ex_t;

   typedef struct packed {
      logic                    valid;
      logic [`PIPE_DATA_W-1:0] alu_result;
      logic                    z;
      logic                    n;
      logic                    ofl;
      logic [`PIPE_DATA_W-1:0] store_data;
      logic [`PIPE_REG_AW-1:0] rd;
      logic                    reg_write;
      logic                    mem_read;
      logic                    mem_write;
      wb_sel_t                 wb_sel;
      logic                    halt;
      logic [`PIPE_DATA_W-1:0] pc4;
   } ex_mem_t;

   typedef struct packed {
      logic                    valid;
      logic [`PIPE_DATA_W-1:0] alu_result;
      logic                    z;
      logic                    n;
      logic                    ofl;
      logic [`PIPE_DATA_W-1:0] mem_data;
      logic [`PIPE_REG_AW-1:0] rd;
      logic                    reg_write;
      wb_sel_t                 wb_sel;
      logic                    halt;
      logic [`PIPE_DATA_W-1:0] pc4;
   } mem_wb_t;

   localparam id_ex_t  ID_EX_BUBBLE  = '0;
   localparam ex_mem_t EX_MEM_BUBBLE = '0;
   localparam mem_wb_t MEM_WB_BUBBLE = '0;

endpackage

`default_nettype wire

// File: hw/pipe_reg.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
   parameter type      payload_t = logic,
   parameter payload_t BUBBLE    = '0
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     stall,
   input  logic     flush,
   input  payload_t d,
   output payload_t q
);

   // A bubble has its valid bit clear, so no later stage acts on it
   always_ff @(posedge clk) begin
      if (rst) begin
         q <= BUBBLE;
      end else if (!stall) begin
         if (flush) begin
            q <= BUBBLE;
         end else begin
            q <= d;
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/exec_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "pipe_params.svh"

module exec_alu import pipe_pkg::*; (
   input  alu_op_t                 op,
   input  logic [`PIPE_DATA_W-1:0] a,
   input  logic [`PIPE_DATA_W-1:0] b,
   output logic [`PIPE_DATA_W-1:0] result,
   output logic                    z,
   output logic                    n,
   output logic                    ofl
);

   localparam int MSB = `PIPE_DATA_W - 1;

   logic [`PIPE_SHAMT_W-1:0] shamt;
   logic                     lt_signed;

   assign shamt     = b[`PIPE_SHAMT_W-1:0];
   assign lt_signed = $signed(a) < $signed(b);

   always_comb begin
      result = '0;
      ofl    = 1'b0;
      case (op)
         ALU_ADD: begin
            result = a + b;
            ofl    = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]); // Like signs, sign flipped
         end
         ALU_SUB: begin
            result = a - b;
            ofl    = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
         end
         ALU_AND:    result = a & b;
         ALU_OR:     result = a | b;
         ALU_XOR:    result = a ^ b;
         ALU_SLT:    result = {{(`PIPE_DATA_W-1){1'b0}}, lt_signed};
         ALU_SLL:    result = a << shamt;
         ALU_SRL:    result = a >> shamt;
         ALU_PASS_B: result = b;
         default:    result = '0;
      endcase
   end

   assign z = (result == '0);
   assign n = result[MSB];

endmodule

`default_nettype wire

// File: hw/data_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "pipe_params.svh"

module data_mem #(
   parameter int ADDR_W = `PIPE_DMEM_AW
) (
   input  logic                    clk,
   input  logic                    we,
   input  logic [ADDR_W-1:0]       addr,
   input  logic [`PIPE_DATA_W-1:0] wdata,
   output logic [`PIPE_DATA_W-1:0] rdata
);

   localparam int DEPTH = 1 << ADDR_W;

   logic [`PIPE_DATA_W-1:0] mem [DEPTH];

   // Contents start at zero to match the architectural view after reset
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr]; // Old word on a same-address write
   end

endmodule

`default_nettype wire

// File: hw/wb_reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "pipe_params.svh"

module wb_reg_file import pipe_pkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`PIPE_REG_AW-1:0] rs,
   input  logic [`PIPE_REG_AW-1:0] rt,
   output logic [`PIPE_DATA_W-1:0] rs_data,
   output logic [`PIPE_DATA_W-1:0] rt_data,
   input  logic                    wb_valid,
   input  logic                    wb_reg_write,
   input  logic [`PIPE_REG_AW-1:0] wb_rd,
   input  wb_sel_t                 wb_sel,
   input  logic [`PIPE_DATA_W-1:0] wb_alu,
   input  logic [`PIPE_DATA_W-1:0] wb_mem,
   input  logic [`PIPE_DATA_W-1:0] wb_pc4,
   output logic [`PIPE_DATA_W-1:0] wb_data
);

   logic [`PIPE_DATA_W-1:0] regs [`PIPE_REG_NUM];
   logic                    wr_en;

   always_comb begin
      case (wb_sel)
         WB_MEM:  wb_data = wb_mem;
         WB_PC4:  wb_data = wb_pc4;
         default: wb_data = wb_alu;
      endcase
   end

   assign wr_en = wb_valid && wb_reg_write && (wb_rd != '0); // Register 0 is never written

   // Write-through lets an instruction read the value retiring this cycle
   function automatic logic [`PIPE_DATA_W-1:0] read_port(input logic [`PIPE_REG_AW-1:0] sel);
      logic [`PIPE_DATA_W-1:0] val;
      if (sel == '0) begin
         val = '0;
      end else if (wr_en && (sel == wb_rd)) begin
         val = wb_data;
      end else begin
         val = regs[sel];
      end
      return val;
   endfunction

   always_comb begin
      rs_data = read_port(rs);
      rt_data = read_port(rt);
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `PIPE_REG_NUM; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wb_rd] <= wb_data;
      end
   end

endmodule

`default_nettype wire

// File: hw/pipe_backend.sv
`timescale 1ns/100ps
`default_nettype none

`include "pipe_params.svh"

module pipe_backend import pipe_pkg::*; (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    stall,
   input  logic                    flush_ex,
   input  logic                    issue_valid,
   input  alu_op_t                 issue_op,
   input  logic [`PIPE_REG_AW-1:0] issue_rs,
   input  logic [`PIPE_REG_AW-1:0] issue_rt,
   input  logic [`PIPE_REG_AW-1:0] issue_rd,
   input  logic [`PIPE_DATA_W-1:0] issue_imm,
   input  logic                    issue_use_imm,
   input  logic                    issue_mem_read,
   input  logic                    issue_mem_write,
   input  wb_sel_t                 issue_wb_sel,
   input  logic                    issue_reg_write,
   input  logic                    issue_halt,
   input  logic [`PIPE_DATA_W-1:0] issue_pc,
   output logic                    retire_valid,
   output logic [`PIPE_REG_AW-1:0] retire_rd,
   output logic                    retire_reg_write,
   output logic [`PIPE_DATA_W-1:0] retire_data,
   output logic                    retire_z,
   output logic                    retire_n,
   output logic                    retire_ofl,
   output logic [`PIPE_DATA_W-1:0] retire_pc4,
   output logic                    halted
);

   id_ex_t  id_ex_d;
   id_ex_t  id_ex_q;
   ex_mem_t ex_mem_d;
   ex_mem_t ex_mem_q;
   mem_wb_t mem_wb_d;
   mem_wb_t mem_wb_q;

   logic [`PIPE_DATA_W-1:0]  rs_data;
   logic [`PIPE_DATA_W-1:0]  rt_data;
   logic [`PIPE_DATA_W-1:0]  alu_result;
   logic                     alu_z;
   logic                     alu_n;
   logic                     alu_ofl;
   logic                     dmem_we;
   logic [`PIPE_DMEM_AW-1:0] dmem_addr;
   logic [`PIPE_DATA_W-1:0]  dmem_rdata;
   logic [`PIPE_DATA_W-1:0]  wb_data;
   logic                     halt_q;
   logic                     retire_halt;

   // Operand read and ID/EX register
   always_comb begin
      id_ex_d            = ID_EX_BUBBLE;
      id_ex_d.valid      = issue_valid;
      id_ex_d.op         = issue_op;
      id_ex_d.a          = rs_data;
      id_ex_d.b          = issue_use_imm ? issue_imm : rt_data;
      id_ex_d.store_data = rt_data;
      id_ex_d.rd         = issue_rd;
      id_ex_d.reg_write  = issue_reg_write;
      id_ex_d.mem_read   = issue_mem_read;
      id_ex_d.mem_write  = issue_mem_write;
      id_ex_d.wb_sel     = issue_wb_sel;
      id_ex_d.halt       = issue_halt;
      id_ex_d.pc4        = issue_pc + `PIPE_DATA_W'd4;
   end

   pipe_reg #(.payload_t(id_ex_t), .BUBBLE(ID_EX_BUBBLE)) id_ex_reg (
      .clk   (clk),
      .rst   (rst),
      .stall (stall),
      .flush (1'b0),
      .d     (id_ex_d),
      .q     (id_ex_q)
   );

   // Execute and EX/MEM register
   exec_alu alu_i (
      .op     (id_ex_q.op),
      .a      (id_ex_q.a),
      .b      (id_ex_q.b),
      .result (alu_result),
      .z      (alu_z),
      .n      (alu_n),
      .ofl    (alu_ofl)
   );

   always_comb begin
      ex_mem_d            = EX_MEM_BUBBLE;
      ex_mem_d.valid      = id_ex_q.valid;
      ex_mem_d.alu_result = alu_result;
      ex_mem_d.z          = alu_z;
      ex_mem_d.n          = alu_n;
      ex_mem_d.ofl        = alu_ofl;
      ex_mem_d.store_data = id_ex_q.store_data;
      ex_mem_d.rd         = id_ex_q.rd;
      ex_mem_d.reg_write  = id_ex_q.reg_write;
      ex_mem_d.mem_read   = id_ex_q.mem_read;
      ex_mem_d.mem_write  = id_ex_q.mem_write;
      ex_mem_d.wb_sel     = id_ex_q.wb_sel;
      ex_mem_d.halt       = id_ex_q.halt;
      ex_mem_d.pc4        = id_ex_q.pc4;
   end

   pipe_reg #(.payload_t(ex_mem_t), .BUBBLE(EX_MEM_BUBBLE)) ex_mem_reg (
      .clk   (clk),
      .rst   (rst),
      .stall (stall),
      .flush (flush_ex),
      .d     (ex_mem_d),
      .q     (ex_mem_q)
   );

   // The memory is accessed on the same edge that moves an instruction into EX/MEM
   assign dmem_we   = id_ex_q.valid && id_ex_q.mem_write && !stall && !flush_ex;
   assign dmem_addr = stall ? ex_mem_q.alu_result[`PIPE_DMEM_AW-1:0]
                            : alu_result[`PIPE_DMEM_AW-1:0]; // Keep the held load's word

   data_mem #(.ADDR_W(`PIPE_DMEM_AW)) dmem_i (
      .clk   (clk),
      .we    (dmem_we),
      .addr  (dmem_addr),
      .wdata (id_ex_q.store_data),
      .rdata (dmem_rdata)
   );

   always_comb begin
      mem_wb_d            = MEM_WB_BUBBLE;
      mem_wb_d.valid      = ex_mem_q.valid;
      mem_wb_d.alu_result = ex_mem_q.alu_result;
      mem_wb_d.z          = ex_mem_q.z;
      mem_wb_d.n          = ex_mem_q.n;
      mem_wb_d.ofl        = ex_mem_q.ofl;
      mem_wb_d.mem_data   = ex_mem_q.mem_read ? dmem_rdata : '0;
      mem_wb_d.rd         = ex_mem_q.rd;
      mem_wb_d.reg_write  = ex_mem_q.reg_write;
      mem_wb_d.wb_sel     = ex_mem_q.wb_sel;
      mem_wb_d.halt       = ex_mem_q.halt;
      mem_wb_d.pc4        = ex_mem_q.pc4;
   end

   // Stall inserts a bubble here so a held instruction retires once
   pipe_reg #(.payload_t(mem_wb_t), .BUBBLE(MEM_WB_BUBBLE)) mem_wb_reg (
      .clk   (clk),
      .rst   (rst),
      .stall (1'b0),
      .flush (stall),
      .d     (mem_wb_d),
      .q     (mem_wb_q)
   );

   // Writeback into the register file
   wb_reg_file rf_i (
      .clk          (clk),
      .rst          (rst),
      .rs           (issue_rs),
      .rt           (issue_rt),
      .rs_data      (rs_data),
      .rt_data      (rt_data),
      .wb_valid     (mem_wb_q.valid),
      .wb_reg_write (mem_wb_q.reg_write),
      .wb_rd        (mem_wb_q.rd),
      .wb_sel       (mem_wb_q.wb_sel),
      .wb_alu       (mem_wb_q.alu_result),
      .wb_mem       (mem_wb_q.mem_data),
      .wb_pc4       (mem_wb_q.pc4),
      .wb_data      (wb_data)
   );

   assign retire_valid     = mem_wb_q.valid;
   assign retire_rd        = mem_wb_q.rd;
   assign retire_reg_write = mem_wb_q.reg_write;
   assign retire_data      = wb_data;
   assign retire_z         = mem_wb_q.z;
   assign retire_n         = mem_wb_q.n;
   assign retire_ofl       = mem_wb_q.ofl;
   assign retire_pc4       = mem_wb_q.pc4;

   assign retire_halt = mem_wb_q.valid && mem_wb_q.halt;

   always_ff @(posedge clk) begin
      if (rst) begin
         halt_q <= 1'b0;
      end else if (retire_halt) begin
         halt_q <= 1'b1;
      end
   end

   assign halted = halt_q || retire_halt; // High from the retiring cycle on

endmodule

`default_nettype wire

// File: testbench/pipe_backend_properties.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_backend_properties (
   input wire logic clk,
   input wire logic rst,
   input wire logic stall,
   input wire logic issue_valid,
   input wire logic retire_valid,
   input wire logic halted
);

   // Nothing can reach writeback before three edges have passed
   reset_quiet: assert property (@(posedge clk)
      $fell(rst) |-> !retire_valid ##1 !retire_valid ##1 !retire_valid)
      else $error("retire_valid seen within three cycles of reset release");

   no_issue_in_stall: assert property (@(posedge clk) disable iff (rst)
      stall |-> !issue_valid)
      else $error("issue_valid raised while stall is high");

   halted_sticky: assert property (@(posedge clk) disable iff (rst)
      halted |=> halted)
      else $error("halted fell without reset");

endmodule

bind pipe_backend pipe_backend_properties props_i (
   .clk          (clk),
   .rst          (rst),
   .stall        (stall),
   .issue_valid  (issue_valid),
   .retire_valid (retire_valid),
   .halted       (halted)
);

`default_nettype wire

// File: testbench/pipe_backend_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "pipe_params.svh"

module pipe_backend_tb import pipe_pkg::*; ();

   localparam int kind_alu   = 0;
   localparam int kind_load  = 1;
   localparam int kind_store = 2;
   localparam int kind_link  = 3;
   localparam int kind_halt  = 4;
   localparam int kind_nop   = 5;
   localparam int rand_count = 200;

   typedef struct {
      int          kind;
      alu_op_t     op;
      logic [4:0]  rs, rt, rd;
      logic [31:0] imm;
      logic        use_imm;
      logic        stall;
      logic        flush;
      logic [31:0] exp_data;
   } row_t;

   typedef struct {
      logic [4:0]  rd;
      logic [31:0] data;
      logic        z, n, ofl;
      logic        reg_write;
      logic        halt;
      logic [31:0] pc4;
      int          tag;
   } exp_t;

   logic clk = 1'b0;
   logic rst;
   logic stall;
   logic flush_ex;
   logic issue_valid;
   alu_op_t issue_op;
   logic [4:0] issue_rs, issue_rt, issue_rd;
   logic [31:0] issue_imm;
   logic issue_use_imm;
   logic issue_mem_read;
   logic issue_mem_write;
   wb_sel_t issue_wb_sel;
   logic issue_reg_write;
   logic issue_halt;
   logic [31:0] issue_pc;
   logic retire_valid;
   logic [4:0] retire_rd;
   logic retire_reg_write;
   logic [31:0] retire_data;
   logic retire_z, retire_n, retire_ofl;
   logic [31:0] retire_pc4;
   logic halted;

   row_t        table_q [$];
   exp_t        exp_q [$];
   logic [31:0] model_regs [32];
   logic [31:0] model_mem [256];
   logic [31:0] rng = 32'hde74c1a9;
   logic        exp_halted;
   int          ns_count;
   int          errors;
   int          checks;
   int          cycles;
   int          limit = 100000;

   pipe_backend dut_i (.*);

   always #50 clk = ~clk;

   always @(posedge clk) begin
      if (!rst) cycles++;
      if (cycles > limit) begin
         $display("Timeout: run exceeded %0d cycles with %0d retirements pending",
                  limit, exp_q.size());
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] v;
      v = x ^ (x << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   // Reference ALU written from the operation definitions
   function automatic void alu_ref(input alu_op_t op, input logic [31:0] a, input logic [31:0] b,
                                   output logic [31:0] r, output logic ofl);
      longint wide;
      ofl = 1'b0;
      case (op)
         ALU_ADD: begin
            wide = longint'($signed(a)) + longint'($signed(b));
            r    = a + b;
            ofl  = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
         end
         ALU_SUB: begin
            wide = longint'($signed(a)) - longint'($signed(b));
            r    = a - b;
            ofl  = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
         end
         ALU_AND:    r = a & b;
         ALU_OR:     r = a | b;
         ALU_XOR:    r = a ^ b;
         ALU_SLT:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         ALU_SLL:    r = a << b[4:0];
         ALU_SRL:    r = a >> b[4:0];
         ALU_PASS_B: r = b;
         default:    r = 32'd0;
      endcase
   endfunction

   task automatic add_row(input int kind, input alu_op_t op, input int rs, input int rt,
                          input int rd, input logic [31:0] imm, input logic use_imm,
                          input logic st, input logic fl, input logic [31:0] exp_data);
      row_t r;
      r.kind     = kind;
      r.op       = op;
      r.rs       = 5'(rs);
      r.rt       = 5'(rt);
      r.rd       = 5'(rd);
      r.imm      = imm;
      r.use_imm  = use_imm;
      r.stall    = st;
      r.flush    = fl;
      r.exp_data = exp_data;
      table_q.push_back(r);
   endtask

   function automatic row_t nop_row();
      row_t r;
      r = '{kind_nop, ALU_ADD, 5'd0, 5'd0, 5'd0, 32'd0, 1'b0, 1'b0, 1'b0, 32'd0};
      return r;
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // Outputs are read half a cycle after the edge that set them
   task automatic check_retire();
      logic edge_stall;
      exp_t e;
      edge_stall = stall;
      if (!edge_stall) ns_count++;
      if (retire_valid) begin
         assert (!edge_stall) else begin
            $display("%0t: an instruction retired right after a stall cycle", $time);
            errors++;
         end
         if (exp_q.size() == 0) begin
            assert (0) else begin
               $display("%0t: retirement seen with no instruction expected", $time);
               errors++;
            end
         end else begin
            e = exp_q.pop_front();
            assert (ns_count == e.tag) else begin
               $display("%0t: instruction for r%0d retired at the wrong cycle", $time, e.rd);
               errors++;
            end
            compare("retire_rd", 32'(retire_rd), 32'(e.rd));
            compare("retire_reg_write", 32'(retire_reg_write), 32'(e.reg_write));
            compare("retire_data", retire_data, e.data);
            compare("retire_z", 32'(retire_z), 32'(e.z));
            compare("retire_n", 32'(retire_n), 32'(e.n));
            compare("retire_ofl", 32'(retire_ofl), 32'(e.ofl));
            compare("retire_pc4", retire_pc4, e.pc4);
            if (e.halt) exp_halted = 1'b1;
         end
      end else if (exp_q.size() > 0 && exp_q[0].tag == ns_count && !edge_stall) begin
         e = exp_q.pop_front();
         assert (0) else begin
            $display("%0t: expected retirement of r%0d did not appear", $time, e.rd);
            errors++;
         end
      end
      compare("halted", 32'(halted), 32'(exp_halted));
   endtask

   task automatic model_issue(input row_t r, input logic [31:0] pc, input logic use_tbl);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic [31:0] data;
      exp_t e;
      a = model_regs[r.rs];
      b = r.use_imm ? r.imm : model_regs[r.rt];
      alu_ref(r.op, a, b, res, e.ofl);
      case (r.kind)
         kind_load: data = model_mem[res[7:0]];
         kind_link: data = pc + 32'd4;
         default:   data = res;
      endcase
      if (r.kind == kind_store) model_mem[res[7:0]] = model_regs[r.rt];
      e.reg_write = (r.kind == kind_alu) || (r.kind == kind_load) || (r.kind == kind_link);
      if (e.reg_write && r.rd != 5'd0) model_regs[r.rd] = data;
      e.rd   = r.rd;
      e.data = use_tbl ? r.exp_data : data;
      e.z    = (res == 32'd0);
      e.n    = res[31];
      e.halt = (r.kind == kind_halt);
      e.pc4  = pc + 32'd4;
      e.tag  = ns_count + 3; // Issue edge plus two moves, stalls excluded
      exp_q.push_back(e);
   endtask

   task automatic drive(input row_t r, input logic [31:0] pc);
      issue_valid     = (r.kind != kind_nop);
      issue_op        = r.op;
      issue_rs        = r.rs;
      issue_rt        = r.rt;
      issue_rd        = r.rd;
      issue_imm       = r.imm;
      issue_use_imm   = r.use_imm;
      issue_mem_read  = (r.kind == kind_load);
      issue_mem_write = (r.kind == kind_store);
      issue_wb_sel    = (r.kind == kind_load) ? WB_MEM : (r.kind == kind_link) ? WB_PC4 : WB_ALU;
      issue_reg_write = (r.kind == kind_alu) || (r.kind == kind_load) || (r.kind == kind_link);
      issue_halt      = (r.kind == kind_halt);
      issue_pc        = pc;
      stall           = r.stall;
      flush_ex        = r.flush;
   endtask

   task automatic run_cycle(input row_t r, input logic [31:0] pc, input logic flushed,
                            input logic use_tbl);
      @(negedge clk);
      check_retire();
      if (r.kind != kind_nop && !flushed) model_issue(r, pc, use_tbl);
      drive(r, pc);
   endtask

   task automatic build_table();
      add_row(kind_alu,   ALU_PASS_B, 0, 0, 1,  32'h5,        1, 0, 0, 32'h5);
      add_row(kind_alu,   ALU_PASS_B, 0, 0, 2,  32'h80000000, 1, 0, 0, 32'h80000000);
      add_row(kind_alu,   ALU_PASS_B, 0, 0, 3,  32'h7fffffff, 1, 0, 0, 32'h7fffffff);
      add_row(kind_alu,   ALU_ADD,    1, 1, 4,  32'h0,        0, 0, 0, 32'ha);
      add_row(kind_alu,   ALU_SUB,    2, 1, 6,  32'h0,        0, 0, 0, 32'h7ffffffb);
      add_row(kind_alu,   ALU_ADD,    3, 0, 5,  32'h1,        1, 0, 0, 32'h80000000);
      add_row(kind_alu,   ALU_AND,    3, 0, 7,  32'hf0,       1, 0, 0, 32'hf0);
      add_row(kind_alu,   ALU_OR,     1, 2, 8,  32'h0,        0, 0, 0, 32'h80000005);
      add_row(kind_alu,   ALU_XOR,    3, 3, 9,  32'h0,        0, 0, 0, 32'h0);
      add_row(kind_alu,   ALU_SLT,    2, 1, 10, 32'h0,        0, 0, 0, 32'h1);
      add_row(kind_alu,   ALU_SLL,    1, 0, 11, 32'h4,        1, 0, 0, 32'h50);
      add_row(kind_alu,   ALU_SRL,    2, 0, 12, 32'h1f,       1, 0, 0, 32'h1);
      add_row(kind_alu,   ALU_ADD,    1, 0, 0,  32'h7,        1, 0, 0, 32'hc);
      add_row(kind_store, ALU_ADD,    1, 3, 0,  32'h3,        1, 0, 0, 32'h8);
      add_row(kind_load,  ALU_ADD,    0, 0, 13, 32'h8,        1, 0, 0, 32'h7fffffff);
      add_row(kind_link,  ALU_PASS_B, 0, 0, 14, 32'h0,        1, 0, 0, 32'h140);
      add_row(kind_alu,   ALU_ADD,    0, 1, 15, 32'h0,        0, 0, 0, 32'h5);
      add_row(kind_alu,   ALU_ADD,    4, 0, 16, 32'h1,        1, 0, 0, 32'hb);
      add_row(kind_nop,   ALU_ADD,    0, 0, 0,  32'h0,        0, 1, 0, 32'h0);
      add_row(kind_nop,   ALU_ADD,    0, 0, 0,  32'h0,        0, 1, 0, 32'h0);
      add_row(kind_alu,   ALU_ADD,    13, 0, 17, 32'h0,       1, 0, 0, 32'h7fffffff);
      add_row(kind_alu,   ALU_ADD,    1, 0, 18, 32'h64,       1, 0, 0, 32'h0);
      add_row(kind_nop,   ALU_ADD,    0, 0, 0,  32'h0,        0, 0, 1, 32'h0);
      add_row(kind_store, ALU_ADD,    1, 1, 0,  32'h3,        1, 0, 0, 32'h0);
      add_row(kind_nop,   ALU_ADD,    0, 0, 0,  32'h0,        0, 0, 1, 32'h0);
      add_row(kind_halt,  ALU_ADD,    1, 0, 0,  32'h0,        1, 0, 0, 32'h0);
      add_row(kind_nop,   ALU_ADD,    0, 0, 0,  32'h0,        0, 0, 1, 32'h0);
      add_row(kind_alu,   ALU_ADD,    18, 0, 19, 32'h0,       1, 0, 0, 32'h0);
      add_row(kind_load,  ALU_ADD,    0, 0, 20, 32'h8,        1, 0, 0, 32'h7fffffff);
      add_row(kind_nop,   ALU_ADD,    0, 0, 0,  32'h0,        0, 0, 0, 32'h0);
      add_row(kind_halt,  ALU_ADD,    1, 0, 0,  32'h0,        1, 0, 0, 32'h5);
   endtask

   function automatic row_t random_row();
      row_t r;
      int   k;
      r = nop_row();
      rng = xorshift(rng);
      k = int'(rng % 8);
      r.kind = (k < 5) ? kind_alu : (k == 5) ? kind_load : (k == 6) ? kind_store : kind_link;
      rng = xorshift(rng);
      r.op = alu_op_t'(4'(rng % 9));
      rng = xorshift(rng);
      r.rs = rng[4:0];
      r.rt = rng[9:5];
      r.rd = rng[14:10];
      r.use_imm = rng[15];
      rng = xorshift(rng);
      r.imm = rng;
      if (r.kind == kind_load || r.kind == kind_store) begin
         r.op      = ALU_ADD;
         r.use_imm = 1'b1;
      end
      return r;
   endfunction

   initial begin
      int   base;
      logic flushed;
      row_t r;
      for (int i = 0; i < 32; i++) model_regs[i] = 32'd0;
      for (int i = 0; i < 256; i++) model_mem[i] = 32'd0;
      errors     = 0;
      checks     = 0;
      cycles     = 0;
      ns_count   = 0;
      exp_halted = 1'b0;
      rst        = 1'b1;
      drive(nop_row(), 32'd0);
      repeat (10) @(negedge clk);
      rst = 1'b0;
      build_table();
      limit = table_q.size() + 4 * rand_count + 50;

      base = errors;
      for (int i = 0; i < table_q.size(); i++) begin
         flushed = (i + 1 < table_q.size()) && table_q[i + 1].flush && !table_q[i + 1].stall;
         run_cycle(table_q[i], 32'h100 + 32'(4 * i), flushed, 1'b1);
      end
      repeat (4) run_cycle(nop_row(), 32'd0, 1'b0, 1'b0);
      $display("test table: %0d rows, %0d errors", table_q.size(), errors - base);

      // One issue every third cycle keeps every reader clear of its writer
      base = errors;
      for (int n = 0; n < rand_count; n++) begin
         r = random_row();
         run_cycle(r, 32'h1000 + 32'(4 * n), 1'b0, 1'b0);
         repeat (2) run_cycle(nop_row(), 32'd0, 1'b0, 1'b0);
      end
      while (exp_q.size() > 0) run_cycle(nop_row(), 32'd0, 1'b0, 1'b0);
      $display("test random: %0d instructions, %0d errors", rand_count, errors - base);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/pipe_pkg.sv
hw/pipe_reg.sv
hw/exec_alu.sv
hw/data_mem.sv
hw/wb_reg_file.sv
hw/pipe_backend.sv
testbench/pipe_backend_properties.sv
testbench/pipe_backend_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = pipe_backend_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
